// ==== build.f ====
+incdir+verilog
+incdir+verification
verilog/exec_pkg.sv
verilog/operand_addr_gen.sv
verilog/mem_sequencer.sv
verilog/result_unit.sv
verilog/execute_stage.sv
verification/tb_execute_stage.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
# Compile and run the execute stage testbench with Verilator
set -e

cd "$(dirname "$0")"

LOG=sim.log

verilator --binary --timing -j 0 \
	--top-module tb_execute_stage \
	--Mdir obj_dir -o sim_execute_stage \
	-f build.f

./obj_dir/sim_execute_stage > "$LOG" 2>&1 || true
cat "$LOG"

if grep -q "Checks failed" "$LOG"; then
	echo "Simulation FAILED"
	exit 1
fi
echo "Simulation PASSED"

// ==== verification/tb_vectors.svh ====
`ifndef TB_VECTORS_SVH
`define TB_VECTORS_SVH

// Columns: name, opcode, mode, size, pc, operand, random mask {A,X,Y,PSW}, A, X, Y, PSW,
//          preload address, preload byte, result kind, expected address or reg, expected value

// Immediate ALU and loads
add_vec("adc_imm", `OPC_ADC, `MODE_IMM, 2'd2, 16'h0200, 16'h0025, 4'b0111,
	8'hF0, 8'h00, 8'h00, 8'h00, 16'h0000, 8'h00, K_REG, 16'(`REG_A), 16'h0015);
add_vec("and_imm", `OPC_AND, `MODE_IMM, 2'd2, 16'h0202, 16'h006F, 4'b0111,
	8'hCA, 8'h00, 8'h00, 8'h00, 16'h0000, 8'h00, K_REG, 16'(`REG_A), 16'h004A);
add_vec("eor_imm", `OPC_EOR, `MODE_IMM, 2'd2, 16'h0204, 16'h006F, 4'b0111,
	8'hCA, 8'h00, 8'h00, 8'h00, 16'h0000, 8'h00, K_REG, 16'(`REG_A), 16'h00A5);
add_vec("ora_imm", `OPC_ORA, `MODE_IMM, 2'd2, 16'h0206, 16'h0081, 4'b0111,
	8'h12, 8'h00, 8'h00, 8'h00, 16'h0000, 8'h00, K_REG, 16'(`REG_A), 16'h0093);
add_vec("lda_imm", `OPC_LDA, `MODE_IMM, 2'd2, 16'h0208, 16'h007E, 4'b1111,
	8'h00, 8'h00, 8'h00, 8'h00, 16'h0000, 8'h00, K_REG, 16'(`REG_A), 16'h007E);
add_vec("ldx_imm", `OPC_LDX, `MODE_IMM, 2'd2, 16'h020A, 16'h0080, 4'b1111,
	8'h00, 8'h00, 8'h00, 8'h00, 16'h0000, 8'h00, K_REG, 16'(`REG_X), 16'h0080);
add_vec("ldy_imm", `OPC_LDY, `MODE_IMM, 2'd2, 16'h020C, 16'h0001, 4'b1111,
	8'h00, 8'h00, 8'h00, 8'h00, 16'h0000, 8'h00, K_REG, 16'(`REG_Y), 16'h0001);

// Loads from memory
add_vec("lda_zp", `OPC_LDA, `MODE_ZP, 2'd2, 16'h0300, 16'h5542, 4'b1111,
	8'h00, 8'h00, 8'h00, 8'h00, 16'h0042, 8'hB7, K_REG, 16'(`REG_A), 16'h00B7);
add_vec("lda_zpx_wrap", `OPC_LDA, `MODE_ZPX, 2'd2, 16'h0302, 16'h00F0, 4'b1011,
	8'h00, 8'h20, 8'h00, 8'h00, 16'h0010, 8'h3D, K_REG, 16'(`REG_A), 16'h003D);
add_vec("ldx_zpy", `OPC_LDX, `MODE_ZPY, 2'd2, 16'h0304, 16'h0030, 4'b1101,
	8'h00, 8'h00, 8'h05, 8'h00, 16'h0035, 8'h9A, K_REG, 16'(`REG_X), 16'h009A);
add_vec("ldy_abs", `OPC_LDY, `MODE_ABS, 2'd3, 16'h0306, 16'h1234, 4'b1111,
	8'h00, 8'h00, 8'h00, 8'h00, 16'h1234, 8'h5E, K_REG, 16'(`REG_Y), 16'h005E);
add_vec("lda_absx_carry", `OPC_LDA, `MODE_ABSX, 2'd3, 16'h0309, 16'h12F0, 4'b1011,
	8'h00, 8'h20, 8'h00, 8'h00, 16'h1310, 8'hC4, K_REG, 16'(`REG_A), 16'h00C4);
add_vec("lda_absy", `OPC_LDA, `MODE_ABSY, 2'd3, 16'h030C, 16'h4000, 4'b1101,
	8'h00, 8'h00, 8'h7F, 8'h00, 16'h407F, 8'h21, K_REG, 16'(`REG_A), 16'h0021);

// Stores
add_vec("sta_zp", `OPC_STA, `MODE_ZP, 2'd2, 16'h0400, 16'h0080, 4'b0111,
	8'h5A, 8'h00, 8'h00, 8'h00, 16'h0080, 8'h00, K_MEM, 16'h0080, 16'h005A);
add_vec("stx_abs", `OPC_STX, `MODE_ABS, 2'd3, 16'h0402, 16'h2345, 4'b1011,
	8'h00, 8'hE1, 8'h00, 8'h00, 16'h2345, 8'h00, K_MEM, 16'h2345, 16'h00E1);
add_vec("sty_zpx_wrap", `OPC_STY, `MODE_ZPX, 2'd2, 16'h0405, 16'h00FE, 4'b1001,
	8'h00, 8'h03, 8'h6C, 8'h00, 16'h0001, 8'h00, K_MEM, 16'h0001, 16'h006C);

// Read-modify-write
add_vec("inc_zp", `OPC_INC, `MODE_ZP, 2'd2, 16'h0500, 16'h0090, 4'b1111,
	8'h00, 8'h00, 8'h00, 8'h00, 16'h0090, 8'h41, K_MEM, 16'h0090, 16'h0042);
add_vec("inc_wrap_abs", `OPC_INC, `MODE_ABS, 2'd3, 16'h0502, 16'h3000, 4'b1111,
	8'h00, 8'h00, 8'h00, 8'h00, 16'h3000, 8'hFF, K_MEM, 16'h3000, 16'h0000);
add_vec("dec_zp", `OPC_DEC, `MODE_ZP, 2'd2, 16'h0505, 16'h0091, 4'b1111,
	8'h00, 8'h00, 8'h00, 8'h00, 16'h0091, 8'h10, K_MEM, 16'h0091, 16'h000F);
add_vec("dec_wrap_absx", `OPC_DEC, `MODE_ABSX, 2'd3, 16'h0507, 16'h30FF, 4'b1011,
	8'h00, 8'h01, 8'h00, 8'h00, 16'h3100, 8'h00, K_MEM, 16'h3100, 16'h00FF);

// Compares write C, Z and N, the rest of the PSW passes through
add_vec("cmp_eq_zp", `OPC_CMP, `MODE_ZP, 2'd2, 16'h0600, 16'h0050, 4'b0110,
	8'h40, 8'h00, 8'h00, 8'h40, 16'h0050, 8'h40, K_REG, 16'(`REG_PSW), 16'h0043);
add_vec("cmp_lt_imm", `OPC_CMP, `MODE_IMM, 2'd2, 16'h0602, 16'h0020, 4'b0110,
	8'h10, 8'h00, 8'h00, 8'h03, 16'h0000, 8'h00, K_REG, 16'(`REG_PSW), 16'h0080);
add_vec("cpx_gt_imm", `OPC_CPX, `MODE_IMM, 2'd2, 16'h0604, 16'h0010, 4'b1010,
	8'h00, 8'h90, 8'h00, 8'h80, 16'h0000, 8'h00, K_REG, 16'(`REG_PSW), 16'h0081);
add_vec("cpy_abs", `OPC_CPY, `MODE_ABS, 2'd3, 16'h0606, 16'h2000, 4'b1100,
	8'h00, 8'h00, 8'h05, 8'h24, 16'h2000, 8'h03, K_REG, 16'(`REG_PSW), 16'h0025);

// Branches, target is pc + 2 + signed offset
add_vec("bcc_taken_fwd", `OPC_BCC, `MODE_REL, 2'd2, 16'h0400, 16'h0010, 4'b1110,
	8'h00, 8'h00, 8'h00, 8'h00, 16'h0000, 8'h00, K_REG, 16'(`REG_PC), 16'h0412);
add_vec("bcs_not_taken", `OPC_BCS, `MODE_REL, 2'd2, 16'h0400, 16'h0010, 4'b1110,
	8'h00, 8'h00, 8'h00, 8'h00, 16'h0000, 8'h00, K_NONE, 16'h0000, 16'h0000);
add_vec("beq_taken_back", `OPC_BEQ, `MODE_REL, 2'd2, 16'h0400, 16'h00F0, 4'b1110,
	8'h00, 8'h00, 8'h00, 8'h02, 16'h0000, 8'h00, K_REG, 16'(`REG_PC), 16'h03F2);
add_vec("bne_not_taken", `OPC_BNE, `MODE_REL, 2'd2, 16'h0400, 16'h00F0, 4'b1110,
	8'h00, 8'h00, 8'h00, 8'h02, 16'h0000, 8'h00, K_NONE, 16'h0000, 16'h0000);
add_vec("bmi_taken_fwd", `OPC_BMI, `MODE_REL, 2'd2, 16'h1000, 16'h007F, 4'b1110,
	8'h00, 8'h00, 8'h00, 8'h80, 16'h0000, 8'h00, K_REG, 16'(`REG_PC), 16'h1081);
add_vec("bpl_taken_back", `OPC_BPL, `MODE_REL, 2'd2, 16'h2000, 16'h0080, 4'b1110,
	8'h00, 8'h00, 8'h00, 8'h00, 16'h0000, 8'h00, K_REG, 16'(`REG_PC), 16'h1F82);
add_vec("bvc_not_taken", `OPC_BVC, `MODE_REL, 2'd2, 16'h2000, 16'h0080, 4'b1110,
	8'h00, 8'h00, 8'h00, 8'h40, 16'h0000, 8'h00, K_NONE, 16'h0000, 16'h0000);
add_vec("bvs_taken_page", `OPC_BVS, `MODE_REL, 2'd2, 16'h00FE, 16'h0005, 4'b1110,
	8'h00, 8'h00, 8'h00, 8'h40, 16'h0000, 8'h00, K_REG, 16'(`REG_PC), 16'h0105);

`endif

// ==== verification/tb_execute_stage.sv ====
`timescale 1ns/1ps
`include "exec_cfg.svh"

module tb_execute_stage;

	import exec_pkg::*;

	localparam int MAX_VEC = 64;
	localparam int TIMEOUT = 20;                   // Cycles per wait
	localparam logic [1:0] K_REG  = 2'd0;
	localparam logic [1:0] K_MEM  = 2'd1;
	localparam logic [1:0] K_NONE = 2'd2;          // No write at all

	logic                       clk;
	logic                       rst_n;
	logic                       valid;
	logic [`EXEC_OPC_W-1:0]     opcode;
	logic [`EXEC_MODE_W-1:0]    addr_mode;
	logic [`EXEC_SIZE_W-1:0]    instr_size;
	logic [`EXEC_ADDR_W-1:0]    pc;
	operand_u                   operand;
	logic [`EXEC_DATA_W-1:0]    reg_a;
	logic [`EXEC_DATA_W-1:0]    reg_x;
	logic [`EXEC_DATA_W-1:0]    reg_y;
	logic [`EXEC_DATA_W-1:0]    reg_psw;
	logic [`EXEC_DATA_W-1:0]    mem_data_in = '0;
	logic                       halt_f_to_d;
	logic                       halt_d_to_e;
	logic                       flush_f_to_d;
	logic [`EXEC_ADDR_W-1:0]    addr_bus;
	logic [`EXEC_DATA_W-1:0]    mem_data_out;
	logic                       rw_n;
	logic                       memory_access;
	logic [`EXEC_REGSEL_W-1:0]  reg_addr;
	logic                       reg_write;
	logic [`EXEC_ADDR_W-1:0]    reg_data;

	logic [`EXEC_DATA_W-1:0]    mem [0:65535];
	logic [31:0]                lfsr;
	int                         value_errors;
	int                         other_errors;

	// Event totals and last captured events, written only by the monitors
	int                         reg_total = 0;
	int                         mem_total = 0;
	int                         flush_total = 0;
	logic [`EXEC_REGSEL_W-1:0]  wb_addr = '0;
	logic [`EXEC_ADDR_W-1:0]    wb_data = '0;
	logic                       wb_flush = 1'b0;
	logic [`EXEC_ADDR_W-1:0]    wr_addr = '0;
	logic [`EXEC_DATA_W-1:0]    wr_data = '0;
	logic [`EXEC_ADDR_W-1:0]    rd_addr = '0;
	logic [`EXEC_DATA_W-1:0]    rd_data = '0;

	// Vector table
	string                      v_name [MAX_VEC];
	logic [`EXEC_OPC_W-1:0]     v_opc [MAX_VEC];
	logic [`EXEC_MODE_W-1:0]    v_mode [MAX_VEC];
	logic [`EXEC_SIZE_W-1:0]    v_size [MAX_VEC];
	logic [`EXEC_ADDR_W-1:0]    v_pc [MAX_VEC];
	logic [`EXEC_ADDR_W-1:0]    v_operand [MAX_VEC];
	logic [3:0]                 v_rmask [MAX_VEC];    // Random A, X, Y, PSW
	logic [`EXEC_DATA_W-1:0]    v_a [MAX_VEC];
	logic [`EXEC_DATA_W-1:0]    v_x [MAX_VEC];
	logic [`EXEC_DATA_W-1:0]    v_y [MAX_VEC];
	logic [`EXEC_DATA_W-1:0]    v_psw [MAX_VEC];
	logic [`EXEC_ADDR_W-1:0]    v_mem_addr [MAX_VEC];
	logic [`EXEC_DATA_W-1:0]    v_mem_byte [MAX_VEC];
	logic [1:0]                 v_kind [MAX_VEC];
	logic [`EXEC_ADDR_W-1:0]    v_exp_addr [MAX_VEC];
	logic [`EXEC_ADDR_W-1:0]    v_exp_val [MAX_VEC];
	int                         num_vec = 0;

	execute_stage dut (
		.clk           (clk),
		.rst_n         (rst_n),
		.valid         (valid),
		.opcode        (opcode),
		.addr_mode     (addr_mode),
		.instr_size    (instr_size),
		.pc            (pc),
		.operand       (operand),
		.reg_a         (reg_a),
		.reg_x         (reg_x),
		.reg_y         (reg_y),
		.reg_psw       (reg_psw),
		.mem_data_in   (mem_data_in),
		.halt_f_to_d   (halt_f_to_d),
		.halt_d_to_e   (halt_d_to_e),
		.flush_f_to_d  (flush_f_to_d),
		.addr_bus      (addr_bus),
		.mem_data_out  (mem_data_out),
		.rw_n          (rw_n),
		.memory_access (memory_access),
		.reg_addr      (reg_addr),
		.reg_write     (reg_write),
		.reg_data      (reg_data)
	);

	always #10 clk = ~clk;

	//////////////////////////////////////////////////////////////////////
	// Memory model and write-back monitor
	//////////////////////////////////////////////////////////////////////
	always @(posedge clk)
	begin
		if (memory_access && !rw_n)
		begin
			mem[addr_bus] = mem_data_out;
			wr_addr       <= addr_bus;
			wr_data       <= mem_data_out;
			mem_total     <= mem_total + 1;
		end
		else if (memory_access && rw_n)
		begin
			mem_data_in <= mem[addr_bus];    // Seen by the DUT one edge later
			rd_addr     <= addr_bus;
			rd_data     <= mem[addr_bus];
		end
	end

	always @(posedge clk)
	begin
		if (reg_write)
		begin
			reg_total <= reg_total + 1;
			wb_addr   <= reg_addr;
			wb_data   <= reg_data;
			wb_flush  <= flush_f_to_d;
		end
		if (flush_f_to_d)
			flush_total <= flush_total + 1;
	end

	// Galois LFSR, one step per bit
	function automatic logic lfsr_bit();
		logic b;
		b = lfsr[0];
		lfsr = lfsr >> 1;
		if (b)
			lfsr = lfsr ^ 32'h80200003;
		return b;
	endfunction

	function automatic logic [`EXEC_DATA_W-1:0] rand_byte();
		logic [`EXEC_DATA_W-1:0] v;
		for (int i = 0; i < `EXEC_DATA_W; i++)
			v[i] = lfsr_bit();
		return v;
	endfunction

	task automatic add_vec(input string name, input logic [`EXEC_OPC_W-1:0] opc,
		input logic [`EXEC_MODE_W-1:0] mode, input logic [`EXEC_SIZE_W-1:0] size,
		input logic [`EXEC_ADDR_W-1:0] pc_v, input logic [`EXEC_ADDR_W-1:0] opnd,
		input logic [3:0] rmask, input logic [`EXEC_DATA_W-1:0] a,
		input logic [`EXEC_DATA_W-1:0] x, input logic [`EXEC_DATA_W-1:0] y,
		input logic [`EXEC_DATA_W-1:0] psw, input logic [`EXEC_ADDR_W-1:0] maddr,
		input logic [`EXEC_DATA_W-1:0] mbyte, input logic [1:0] kind,
		input logic [`EXEC_ADDR_W-1:0] exp_addr, input logic [`EXEC_ADDR_W-1:0] exp_val);
		v_name[num_vec]     = name;
		v_opc[num_vec]      = opc;
		v_mode[num_vec]     = mode;
		v_size[num_vec]     = size;
		v_pc[num_vec]       = pc_v;
		v_operand[num_vec]  = opnd;
		v_rmask[num_vec]    = rmask;
		v_a[num_vec]        = a;
		v_x[num_vec]        = x;
		v_y[num_vec]        = y;
		v_psw[num_vec]      = psw;
		v_mem_addr[num_vec] = maddr;
		v_mem_byte[num_vec] = mbyte;
		v_kind[num_vec]     = kind;
		v_exp_addr[num_vec] = exp_addr;
		v_exp_val[num_vec]  = exp_val;
		num_vec++;
	endtask

	task automatic load_vectors();
		`include "tb_vectors.svh"
	endtask

	//////////////////////////////////////////////////////////////////////
	// Compare tasks
	//////////////////////////////////////////////////////////////////////
	task automatic check_reg(input string name,
		input logic [`EXEC_REGSEL_W-1:0] exp_addr, input logic [`EXEC_ADDR_W-1:0] exp_data,
		input logic [`EXEC_REGSEL_W-1:0] act_addr, input logic [`EXEC_ADDR_W-1:0] act_data);
		if (exp_addr !== act_addr || exp_data !== act_data)
		begin
			$display("error %s: expected reg %0d = %h, actual reg %0d = %h",
				name, exp_addr, exp_data, act_addr, act_data);
			value_errors++;
		end
	endtask

	task automatic check_mem(input string name,
		input logic [`EXEC_ADDR_W-1:0] exp_addr, input logic [`EXEC_DATA_W-1:0] exp_data,
		input logic [`EXEC_ADDR_W-1:0] act_addr, input logic [`EXEC_DATA_W-1:0] act_data);
		if (exp_addr !== act_addr || exp_data !== act_data)
		begin
			$display("error %s: expected mem[%h] = %h, actual mem[%h] = %h",
				name, exp_addr, exp_data, act_addr, act_data);
			value_errors++;
		end
	endtask

	task automatic check_flush(input string name, input logic exp_flush, input logic act_flush);
		if (exp_flush !== act_flush)
		begin
			$display("error %s: expected flush %b, actual flush %b", name, exp_flush, act_flush);
			value_errors++;
		end
	endtask

	task automatic report_problem(input string name, input string what);
		$display("%s: %s", name, what);
		other_errors++;
	endtask

	task automatic wait_halt_low(input string name);
		int n;
		n = 0;
		while (halt_d_to_e !== 1'b0 && n < TIMEOUT)
		begin
			@(negedge clk);
			n++;
		end
		if (halt_d_to_e !== 1'b0)
			report_problem(name, "halt_d_to_e did not fall in time");
	endtask

	task automatic wait_reg_write(input string name, input int start);
		int n;
		n = 0;
		while (reg_total == start && n < TIMEOUT)
		begin
			@(negedge clk);
			n++;
		end
		if (reg_total == start)
			report_problem(name, "no register write arrived in time");
	endtask

	task automatic wait_mem_write(input string name, input int start);
		int n;
		n = 0;
		while (mem_total == start && n < TIMEOUT)
		begin
			@(negedge clk);
			n++;
		end
		if (mem_total == start)
			report_problem(name, "no memory write arrived in time");
	endtask

	//////////////////////////////////////////////////////////////////////
	// One table row
	//////////////////////////////////////////////////////////////////////
	task automatic run_vector(input int i);
		int   reg_start;
		int   mem_start;
		int   flush_start;
		logic needs_mem;
		string name;
		name = v_name[i];
		needs_mem = (v_mode[i] != `MODE_IMM) && (v_mode[i] != `MODE_REL);
		wait_halt_low(name);
		reg_start   = reg_total;
		mem_start   = mem_total;
		flush_start = flush_total;
		mem[v_mem_addr[i]] = v_mem_byte[i];
		opcode       = v_opc[i];
		addr_mode    = v_mode[i];
		instr_size   = v_size[i];
		pc           = v_pc[i];
		operand.word = v_operand[i];
		reg_a   = v_rmask[i][3] ? rand_byte() : v_a[i];
		reg_x   = v_rmask[i][2] ? rand_byte() : v_x[i];
		reg_y   = v_rmask[i][1] ? rand_byte() : v_y[i];
		reg_psw = v_rmask[i][0] ? rand_byte() : v_psw[i];
		valid   = 1'b1;
		@(posedge clk);    // Accepted, the halt was low
		@(negedge clk);
		valid = 1'b0;
		if (needs_mem && (halt_d_to_e !== 1'b1 || halt_f_to_d !== 1'b1))
			report_problem(name, "halts not raised during the memory access");
		else if (!needs_mem && (halt_d_to_e !== 1'b0 || halt_f_to_d !== 1'b0))
			report_problem(name, "halt raised for an instruction without memory access");
		wait_halt_low(name);
		if (halt_d_to_e === 1'b0 && halt_f_to_d !== 1'b0)
			report_problem(name, "halt_f_to_d still high after halt_d_to_e fell");
		case (v_kind[i])
			K_REG:
			begin
				wait_reg_write(name, reg_start);
				@(negedge clk);
				if (reg_total - reg_start != 1 || mem_total != mem_start)
					report_problem(name, "wrong number of writes");
				check_reg(name, v_exp_addr[i][`EXEC_REGSEL_W-1:0], v_exp_val[i],
					wb_addr, wb_data);
				check_flush(name, v_exp_addr[i] == 16'(`REG_PC), wb_flush);
				if (needs_mem)
					check_mem(name, v_mem_addr[i], v_mem_byte[i], rd_addr, rd_data);
			end
			K_MEM:
			begin
				wait_mem_write(name, mem_start);
				@(negedge clk);
				if (mem_total - mem_start != 1 || reg_total != reg_start)
					report_problem(name, "wrong number of writes");
				check_mem(name, v_exp_addr[i], v_exp_val[i][`EXEC_DATA_W-1:0], wr_addr, wr_data);
			end
			default:
			begin
				repeat (4) @(negedge clk);
				if (reg_total != reg_start || mem_total != mem_start || flush_total != flush_start)
					report_problem(name, "write or flush seen for a branch not taken");
			end
		endcase
	endtask

	initial
	begin
		clk          = 1'b0;
		rst_n        = 1'b0;
		valid        = 1'b0;
		opcode       = '0;
		addr_mode    = '0;
		instr_size   = '0;
		pc           = '0;
		operand      = '0;
		reg_a        = '0;
		reg_x        = '0;
		reg_y        = '0;
		reg_psw      = '0;
		value_errors = 0;
		other_errors = 0;
		lfsr         = 32'he40ce7c4;
		for (int i = 0; i < 65536; i++)
			mem[i] = rand_byte() ^ i[15:8] ^ i[7:0];
		load_vectors();
		repeat (3) @(posedge clk);
		@(negedge clk);
		if (halt_f_to_d !== 1'b0 || halt_d_to_e !== 1'b0 || flush_f_to_d !== 1'b0 ||
			memory_access !== 1'b0 || reg_write !== 1'b0 || rw_n !== 1'b1)
			report_problem("reset", "outputs are not idle during reset");
		rst_n = 1'b1;
		@(negedge clk);
		for (int i = 0; i < num_vec; i++)
			run_vector(i);
		repeat (2) @(negedge clk);
		$display("Summary: %0d vectors, %0d value errors, %0d other errors",
			num_vec, value_errors, other_errors);
		if (value_errors == 0 && other_errors == 0)
			$display("All checks passed");
		else
			$display("Checks failed");
		$finish;
	end

endmodule

// ==== verilog/execute_stage.sv ====
`timescale 1ns/1ps
`include "exec_cfg.svh"

module execute_stage (
	input  logic                       clk,
	input  logic                       rst_n,
	input  logic                       valid,
	input  logic [`EXEC_OPC_W-1:0]     opcode,
	input  logic [`EXEC_MODE_W-1:0]    addr_mode,
	input  logic [`EXEC_SIZE_W-1:0]    instr_size,
	input  logic [`EXEC_ADDR_W-1:0]    pc,
	input  exec_pkg::operand_u         operand,
	input  logic [`EXEC_DATA_W-1:0]    reg_a,
	input  logic [`EXEC_DATA_W-1:0]    reg_x,
	input  logic [`EXEC_DATA_W-1:0]    reg_y,
	input  logic [`EXEC_DATA_W-1:0]    reg_psw,
	input  logic [`EXEC_DATA_W-1:0]    mem_data_in,
	output logic                       halt_f_to_d,
	output logic                       halt_d_to_e,
	output logic                       flush_f_to_d,
	output logic [`EXEC_ADDR_W-1:0]    addr_bus,
	output logic [`EXEC_DATA_W-1:0]    mem_data_out,
	output logic                       rw_n,
	output logic                       memory_access,
	output logic [`EXEC_REGSEL_W-1:0]  reg_addr,
	output logic                       reg_write,
	output logic [`EXEC_ADDR_W-1:0]    reg_data
);

	import exec_pkg::*;

	logic [`EXEC_ADDR_W-1:0] eff_addr;
	logic                    needs_memory;
	logic                    fire;           // One cycle execute strobe
	logic [`EXEC_DATA_W-1:0] fetched;        // Operand byte for the ALU
	logic [`EXEC_DATA_W-1:0] rmw_value;
	logic [`EXEC_OPC_W-1:0]  lat_opcode;
	logic [`EXEC_MODE_W-1:0] lat_mode;
	logic [`EXEC_ADDR_W-1:0] lat_pc;
	logic [`EXEC_SIZE_W-1:0] lat_size;
	operand_u                lat_operand;

	// Address is formed from the live decode fields, ahead of acceptance
	operand_addr_gen u_addr_gen (
		.addr_mode    (addr_mode),
		.operand      (operand),
		.reg_x        (reg_x),
		.reg_y        (reg_y),
		.eff_addr     (eff_addr),
		.needs_memory (needs_memory)
	);

	mem_sequencer u_seq (
		.clk           (clk),
		.rst_n         (rst_n),
		.valid         (valid),
		.opcode        (opcode),
		.addr_mode     (addr_mode),
		.pc            (pc),
		.operand       (operand),
		.instr_size    (instr_size),
		.reg_a         (reg_a),
		.reg_x         (reg_x),
		.reg_y         (reg_y),
		.eff_addr      (eff_addr),
		.needs_memory  (needs_memory),
		.mem_data_in   (mem_data_in),
		.rmw_value     (rmw_value),
		.halt_f_to_d   (halt_f_to_d),
		.halt_d_to_e   (halt_d_to_e),
		.addr_bus      (addr_bus),
		.mem_data_out  (mem_data_out),
		.rw_n          (rw_n),
		.memory_access (memory_access),
		.fire          (fire),
		.fetched       (fetched),
		.lat_opcode    (lat_opcode),
		.lat_mode      (lat_mode),
		.lat_pc        (lat_pc),
		.lat_operand   (lat_operand),
		.lat_size      (lat_size)
	);

	result_unit u_result (
		.clk          (clk),
		.rst_n        (rst_n),
		.fire         (fire),
		.lat_opcode   (lat_opcode),
		.lat_mode     (lat_mode),
		.lat_pc       (lat_pc),
		.lat_size     (lat_size),
		.lat_operand  (lat_operand),
		.fetched      (fetched),
		.reg_a        (reg_a),
		.reg_x        (reg_x),
		.reg_y        (reg_y),
		.reg_psw      (reg_psw),
		.reg_write    (reg_write),
		.reg_addr     (reg_addr),
		.reg_data     (reg_data),
		.flush_f_to_d (flush_f_to_d),
		.rmw_value    (rmw_value)
	);

endmodule

// ==== verilog/result_unit.sv ====
`timescale 1ns/1ps
`include "exec_cfg.svh"

module result_unit (
	input  logic                      clk,
	input  logic                      rst_n,
	input  logic                      fire,
	input  logic [`EXEC_OPC_W-1:0]    lat_opcode,
	input  logic [`EXEC_MODE_W-1:0]   lat_mode,
	input  logic [`EXEC_ADDR_W-1:0]   lat_pc,
	input  logic [`EXEC_SIZE_W-1:0]   lat_size,
	input  exec_pkg::operand_u        lat_operand,
	input  logic [`EXEC_DATA_W-1:0]   fetched,
	input  logic [`EXEC_DATA_W-1:0]   reg_a,
	input  logic [`EXEC_DATA_W-1:0]   reg_x,
	input  logic [`EXEC_DATA_W-1:0]   reg_y,
	input  logic [`EXEC_DATA_W-1:0]   reg_psw,
	output logic                      reg_write,
	output logic [`EXEC_REGSEL_W-1:0] reg_addr,
	output logic [`EXEC_ADDR_W-1:0]   reg_data,
	output logic                      flush_f_to_d,
	output logic [`EXEC_DATA_W-1:0]   rmw_value
);

	localparam int DW = `EXEC_DATA_W;
	localparam int AW = `EXEC_ADDR_W;

	logic [DW-1:0]             cmp_reg;
	logic [DW:0]               cmp_diff;    // Extra bit is the borrow
	logic [DW-1:0]             cmp_psw;
	logic [DW-1:0]             byte_res;
	logic                      is_rel;
	logic                      br_taken;
	logic [AW-1:0]             br_target;
	logic                      wb_en;
	logic                      wb_flush;
	logic [`EXEC_REGSEL_W-1:0] wb_addr;
	logic [AW-1:0]             wb_data;

	assign rmw_value = (lat_opcode == `OPC_DEC) ? fetched - DW'(1) : fetched + DW'(1);

	// Target is the next instruction plus the signed offset
	assign is_rel    = (lat_mode == `MODE_REL);
	assign br_target = lat_pc + AW'(lat_size) +
		{{(AW-DW){lat_operand.bytes.lo[DW-1]}}, lat_operand.bytes.lo};

	always_comb
	begin
		case (lat_opcode)
			`OPC_CPX: cmp_reg = reg_x;
			`OPC_CPY: cmp_reg = reg_y;
			default:  cmp_reg = reg_a;
		endcase
	end

	assign cmp_diff = {1'b0, cmp_reg} - {1'b0, fetched};

	always_comb
	begin
		cmp_psw         = reg_psw;    // Other flags pass through
		cmp_psw[`PSW_C] = ~cmp_diff[DW];
		cmp_psw[`PSW_Z] = (cmp_reg == fetched);
		cmp_psw[`PSW_N] = cmp_diff[DW-1];
	end

	always_comb
	begin
		case (lat_opcode)
			`OPC_BCC: br_taken = is_rel && !reg_psw[`PSW_C];
			`OPC_BCS: br_taken = is_rel && reg_psw[`PSW_C];
			`OPC_BEQ: br_taken = is_rel && reg_psw[`PSW_Z];
			`OPC_BNE: br_taken = is_rel && !reg_psw[`PSW_Z];
			`OPC_BMI: br_taken = is_rel && reg_psw[`PSW_N];
			`OPC_BPL: br_taken = is_rel && !reg_psw[`PSW_N];
			`OPC_BVS: br_taken = is_rel && reg_psw[`PSW_V];
			`OPC_BVC: br_taken = is_rel && !reg_psw[`PSW_V];
			default:  br_taken = 1'b0;
		endcase
	end

	always_comb
	begin
		wb_en    = 1'b1;
		wb_flush = 1'b0;
		wb_addr  = `REG_A;
		byte_res = fetched;    // Loads pass the operand straight through
		case (lat_opcode)
			`OPC_ADC: byte_res = reg_a + fetched;    // No carry in
			`OPC_AND: byte_res = reg_a & fetched;
			`OPC_EOR: byte_res = reg_a ^ fetched;
			`OPC_ORA: byte_res = reg_a | fetched;
			`OPC_LDA: wb_addr  = `REG_A;
			`OPC_LDX: wb_addr  = `REG_X;
			`OPC_LDY: wb_addr  = `REG_Y;
			`OPC_CMP, `OPC_CPX, `OPC_CPY:
				wb_addr = `REG_PSW;
			`OPC_BCC, `OPC_BCS, `OPC_BEQ, `OPC_BNE,
			`OPC_BMI, `OPC_BPL, `OPC_BVC, `OPC_BVS:
			begin
				wb_en    = br_taken;
				wb_flush = br_taken;
				wb_addr  = `REG_PC;
			end
			default: wb_en = 1'b0;    // Stores and RMW write memory only
		endcase
		if (wb_addr == `REG_PSW)
			wb_data = AW'(cmp_psw);
		else if (wb_addr == `REG_PC)
			wb_data = br_target;
		else
			wb_data = AW'(byte_res);
	end

	//////////////////////////////////////////////////////////////////////
	// Write-back register
	//////////////////////////////////////////////////////////////////////
	always_ff @(posedge clk or negedge rst_n)
	begin
		if (!rst_n)
		begin
			reg_write    <= 1'b0;
			flush_f_to_d <= 1'b0;
		end
		else
		begin
			reg_write    <= fire && wb_en;
			flush_f_to_d <= fire && wb_flush;    // Only with a PC write
		end
	end

	always_ff @(posedge clk)
	begin
		if (fire && wb_en)
		begin
			reg_addr <= wb_addr;
			reg_data <= wb_data;
		end
	end

endmodule

// ==== verilog/mem_sequencer.sv ====
`timescale 1ns/1ps
`include "exec_cfg.svh"

module mem_sequencer (
	input  logic                    clk,
	input  logic                    rst_n,
	input  logic                    valid,
	input  logic [`EXEC_OPC_W-1:0]  opcode,
	input  logic [`EXEC_MODE_W-1:0] addr_mode,
	input  logic [`EXEC_ADDR_W-1:0] pc,
	input  exec_pkg::operand_u      operand,
	input  logic [`EXEC_SIZE_W-1:0] instr_size,
	input  logic [`EXEC_DATA_W-1:0] reg_a,
	input  logic [`EXEC_DATA_W-1:0] reg_x,
	input  logic [`EXEC_DATA_W-1:0] reg_y,
	input  logic [`EXEC_ADDR_W-1:0] eff_addr,
	input  logic                    needs_memory,
	input  logic [`EXEC_DATA_W-1:0] mem_data_in,
	input  logic [`EXEC_DATA_W-1:0] rmw_value,
	output logic                    halt_f_to_d,
	output logic                    halt_d_to_e,
	output logic [`EXEC_ADDR_W-1:0] addr_bus,
	output logic [`EXEC_DATA_W-1:0] mem_data_out,
	output logic                    rw_n,
	output logic                    memory_access,
	output logic                    fire,
	output logic [`EXEC_DATA_W-1:0] fetched,
	output logic [`EXEC_OPC_W-1:0]  lat_opcode,
	output logic [`EXEC_MODE_W-1:0] lat_mode,
	output logic [`EXEC_ADDR_W-1:0] lat_pc,
	output exec_pkg::operand_u      lat_operand,
	output logic [`EXEC_SIZE_W-1:0] lat_size
);

	localparam logic [2:0] ST_IDLE  = 3'd0;
	localparam logic [2:0] ST_READ  = 3'd1;    // Read request on the bus
	localparam logic [2:0] ST_CAPT  = 3'd2;    // Read data on mem_data_in
	localparam logic [2:0] ST_WRITE = 3'd3;    // Store or RMW write on the bus
	localparam logic [2:0] ST_DONE  = 3'd4;    // Execute cycle without memory

	logic [2:0]              state;
	logic                    halt;
	logic                    accept;
	logic                    lat_rmw;
	logic [`EXEC_DATA_W-1:0] store_data;

	function automatic logic is_store(input logic [`EXEC_OPC_W-1:0] opc);
		is_store = (opc == `OPC_STA) || (opc == `OPC_STX) || (opc == `OPC_STY);
	endfunction

	function automatic logic is_rmw(input logic [`EXEC_OPC_W-1:0] opc);
		is_rmw = (opc == `OPC_INC) || (opc == `OPC_DEC);
	endfunction

	assign accept      = valid && !halt;
	assign lat_rmw     = is_rmw(lat_opcode);
	assign halt_f_to_d = halt;
	assign halt_d_to_e = halt;

	always_comb
	begin
		case (opcode)
			`OPC_STX: store_data = reg_x;
			`OPC_STY: store_data = reg_y;
			default:  store_data = reg_a;
		endcase
	end

	// Read-modify-write ops finish on their write, not on the read data
	assign fire    = (state == ST_DONE) || ((state == ST_CAPT) && !lat_rmw);
	assign fetched = (state == ST_CAPT) ? mem_data_in : lat_operand.bytes.lo;

	//////////////////////////////////////////////////////////////////////
	// Accepted instruction
	//////////////////////////////////////////////////////////////////////
	always_ff @(posedge clk)
	begin
		if (accept)
		begin
			lat_opcode  <= opcode;
			lat_mode    <= addr_mode;
			lat_pc      <= pc;
			lat_operand <= operand;
			lat_size    <= instr_size;
		end
	end

	//////////////////////////////////////////////////////////////////////
	// Control FSM and bus strobes
	//////////////////////////////////////////////////////////////////////
	always_ff @(posedge clk or negedge rst_n)
	begin
		if (!rst_n)
		begin
			state         <= ST_IDLE;
			halt          <= 1'b0;
			memory_access <= 1'b0;
			rw_n          <= 1'b1;
		end
		else
		begin
			case (state)
				ST_READ:
				begin
					memory_access <= 1'b0;    // Single cycle request
					state         <= ST_CAPT;
				end
				ST_CAPT:
				begin
					if (lat_rmw)
					begin
						memory_access <= 1'b1;
						rw_n          <= 1'b0;
						state         <= ST_WRITE;
					end
					else
					begin
						halt  <= 1'b0;
						state <= ST_IDLE;
					end
				end
				ST_WRITE:
				begin
					memory_access <= 1'b0;
					rw_n          <= 1'b1;
					halt          <= 1'b0;
					state         <= ST_IDLE;
				end
				default: state <= ST_IDLE;
			endcase

			// A new instruction only arrives while the halt is low
			if (accept)
			begin
				if (!needs_memory)
					state <= ST_DONE;
				else
				begin
					halt          <= 1'b1;
					memory_access <= 1'b1;
					rw_n          <= !is_store(opcode);
					state         <= is_store(opcode) ? ST_WRITE : ST_READ;
				end
			end
		end
	end

	// Bus address and write data
	always_ff @(posedge clk)
	begin
		if (accept && needs_memory)
		begin
			addr_bus     <= eff_addr;
			mem_data_out <= store_data;
		end
		else if ((state == ST_CAPT) && lat_rmw)
			mem_data_out <= rmw_value;    // Same address, modified byte
	end

endmodule

// ==== verilog/operand_addr_gen.sv ====
`timescale 1ns/1ps
`include "exec_cfg.svh"

module operand_addr_gen (
	input  logic [`EXEC_MODE_W-1:0] addr_mode,
	input  exec_pkg::operand_u      operand,
	input  logic [`EXEC_DATA_W-1:0] reg_x,
	input  logic [`EXEC_DATA_W-1:0] reg_y,
	output logic [`EXEC_ADDR_W-1:0] eff_addr,
	output logic                    needs_memory
);

	localparam int DW = `EXEC_DATA_W;
	localparam int AW = `EXEC_ADDR_W;

	logic [DW-1:0] zpx_lo;    // Wraps inside page zero
	logic [DW-1:0] zpy_lo;
	logic [AW-1:0] absx_addr; // Carries into the high byte
	logic [AW-1:0] absy_addr;

	assign zpx_lo    = operand.bytes.lo + reg_x;
	assign zpy_lo    = operand.bytes.lo + reg_y;
	assign absx_addr = operand.word + AW'(reg_x);
	assign absy_addr = operand.word + AW'(reg_y);

	// Immediate and relative take their operand from the instruction itself
	assign needs_memory = (addr_mode != `MODE_IMM) && (addr_mode != `MODE_REL);

	always_comb
	begin
		case (addr_mode)
			`MODE_ZP:   eff_addr = {{(AW-DW){1'b0}}, operand.bytes.lo};
			`MODE_ZPX:  eff_addr = {{(AW-DW){1'b0}}, zpx_lo};
			`MODE_ZPY:  eff_addr = {{(AW-DW){1'b0}}, zpy_lo};
			`MODE_ABSX: eff_addr = absx_addr;
			`MODE_ABSY: eff_addr = absy_addr;
			default:    eff_addr = operand.word;    // Absolute
		endcase
	end

endmodule

// ==== verilog/exec_pkg.sv ====
`include "exec_cfg.svh"

package exec_pkg;

	// Operand word from decode
	// Absolute modes read the full word, the others only the low byte
	typedef union packed {
		logic [`EXEC_ADDR_W-1:0] word;
		struct packed {
			logic [`EXEC_DATA_W-1:0] hi;    // Address high byte
			logic [`EXEC_DATA_W-1:0] lo;    // Immediate, zero page or offset
		} bytes;
	} operand_u;

endpackage

// ==== verilog/exec_cfg.svh ====
`ifndef EXEC_CFG_SVH
`define EXEC_CFG_SVH

//////////////////////////////////////////////////////////////////////
// Field widths
//////////////////////////////////////////////////////////////////////
`define EXEC_DATA_W    8       // Byte datapath
`define EXEC_ADDR_W    16      // Address bus and PC
`define EXEC_OPC_W     6       // Opcode field from decode
`define EXEC_MODE_W    4
`define EXEC_SIZE_W    2       // Instruction length in bytes
`define EXEC_REGSEL_W  3       // Register file index

//////////////////////////////////////////////////////////////////////
// Addressing modes
//////////////////////////////////////////////////////////////////////
`define MODE_IMM   4'd2
`define MODE_ABS   4'd3
`define MODE_ZP    4'd4
`define MODE_ZPX   4'd5
`define MODE_ABSX  4'd6
`define MODE_REL   4'd8        // Branch offset in low byte
`define MODE_ZPY   4'd12
`define MODE_ABSY  4'd13

//////////////////////////////////////////////////////////////////////
// Opcodes
//////////////////////////////////////////////////////////////////////
`define OPC_ADC  6'd1
`define OPC_AND  6'd2
`define OPC_BCC  6'd4
`define OPC_BCS  6'd5
`define OPC_BEQ  6'd6
`define OPC_BMI  6'd8
`define OPC_BNE  6'd9
`define OPC_BPL  6'd10
`define OPC_BVC  6'd12
`define OPC_BVS  6'd13
`define OPC_CMP  6'd18
`define OPC_CPX  6'd19
`define OPC_CPY  6'd20
`define OPC_DEC  6'd21         // Memory read-modify-write
`define OPC_EOR  6'd24
`define OPC_INC  6'd25         // Memory read-modify-write
`define OPC_LDA  6'd30
`define OPC_LDX  6'd31
`define OPC_LDY  6'd32
`define OPC_ORA  6'd35
`define OPC_STA  6'd48
`define OPC_STX  6'd49
`define OPC_STY  6'd50

// Register file indices
`define REG_A    3'd0
`define REG_X    3'd1
`define REG_Y    3'd2
`define REG_PC   3'd3
`define REG_PSW  3'd4

// PSW flag positions
`define PSW_C  0
`define PSW_Z  1
`define PSW_V  6
`define PSW_N  7

`endif
